// File: dv/fb_stimulus.txt
# P index rgb  palette entry, rgb as hex | B x y w h index  box in framebuffer pixels
# C sx sy rgb  screen checkpoint with the expected colour as hex
P 0 000
P 1 F00
P 2 0F0
P 3 00F
P 4 FF0
P 5 0FF
P 6 F0F
P 7 888
P 8 F80
P 9 08F
P 10 8F0
P 11 F08
P 12 444
P 13 CCC
P 14 A52
P 15 FFF
B 20 10 20 15 1
B 40 10 20 15 2
B 0 0 1 1 3
B 159 119 1 1 4
C 80 40 F00
C 159 99 F00
C 160 40 0F0
C 239 99 0F0
C 0 0 00F
C 3 3 00F
C 636 476 FF0
C 639 479 FF0

// File: sources.f
design/fb_pkg.sv
design/disp_if.sv
design/display_timing.sv
design/sdp_ram.sv
design/axil_fb_slave.sv
design/line_scaler_ctrl.sv
design/line_buffer.sv
design/fb_display_top.sv
dv/fb_display_tb.sv

// File: Makefile
TOP := fb_display_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module fb_display_top

clean:
	rm -rf obj_dir

// File: dv/fb_display_tb.sv
// ================================================
// testbench for fb_display_top with axi driver,
// framebuffer/palette model, frame scanner, checks
// ================================================
`default_nettype none
`timescale 1ns/1ps

module fb_display_tb;

    localparam int FB_W      = 160;
    localparam int FB_H      = 120;
    localparam int SCALE     = 4;
    localparam int LINE_LEN  = 800;     // 640 active + 160 blank
    localparam int WAIT_MAX  = 64;      // axi handshake limit in cycles
    localparam int FRAME_MAX = 500000;  // one frame is 420000 cycles
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    logic        clk_pix;
    logic        rst;
    logic [19:0] s_axil_awaddr;
    logic        s_axil_awvalid;
    logic        s_axil_awready;
    logic [31:0] s_axil_wdata;
    logic [3:0]  s_axil_wstrb;
    logic        s_axil_wvalid;
    logic        s_axil_wready;
    logic [1:0]  s_axil_bresp;
    logic        s_axil_bvalid;
    logic        s_axil_bready;
    logic [19:0] s_axil_araddr;
    logic        s_axil_arvalid;
    logic        s_axil_arready;
    logic [31:0] s_axil_rdata;
    logic [1:0]  s_axil_rresp;
    logic        s_axil_rvalid;
    logic        s_axil_rready;
    logic        vga_hsync, vga_vsync, vga_de;
    logic [3:0]  vga_r, vga_g, vga_b;

    logic [3:0]  fb_model [FB_W*FB_H];  // mirror of every fb write
    logic [11:0] pal_model [16];
    int          bx[16], by[16], bw[16], bh[16], bi[16];
    int          n_box;
    int          cx[32], cy[32];
    logic [11:0] cc[32];                 // expected checkpoint colours
    int          n_chk;
    logic [31:0] rng_state;

    fb_display_top fb_display_top_inst (.*);

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;  // 4 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic stop_on_failure(input string what);
        $display("Error: %s", what);
        $display("Finished with errors");
        $fatal(1, "stopping after failure");
    endtask

    // one cycle forward counted against a limit
    task automatic next_cycle(inout int t, input int limit, input string what);
        @(negedge clk_pix);
        t++;
        if (t > limit) stop_on_failure($sformatf("timed out waiting for %s", what));
    endtask

    task automatic axi_write(input logic [19:0] addr, input logic [31:0] data,
                             input int hold, output logic [1:0] resp);
        int t;
        int i;
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        s_axil_bready  = (hold == 0);  // held low for back-pressure test
        t = 0;
        while (!(s_axil_awready && s_axil_wready)) next_cycle(t, WAIT_MAX, "awready/wready");
        @(negedge clk_pix);  // aw and w taken on the edge before
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        t = 0;
        while (!s_axil_bvalid) next_cycle(t, WAIT_MAX, "bvalid");
        for (i = 0; i < hold; i++) begin
            @(negedge clk_pix);
            check("bvalid held while bready low", 1, s_axil_bvalid);
        end
        s_axil_bready = 1'b1;
        resp = s_axil_bresp;
        @(negedge clk_pix);
        s_axil_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [19:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int t;
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        s_axil_rready  = 1'b1;
        t = 0;
        while (!s_axil_arready) next_cycle(t, WAIT_MAX, "arready");
        @(negedge clk_pix);
        s_axil_arvalid = 1'b0;
        t = 0;
        while (!s_axil_rvalid) next_cycle(t, WAIT_MAX, "rvalid");
        data = s_axil_rdata;
        resp = s_axil_rresp;
        @(negedge clk_pix);
        s_axil_rready = 1'b0;
    endtask

    task automatic write_pixel(input int idx, input logic [3:0] cidx);
        logic [1:0] resp;
        axi_write(20'(idx), 32'(cidx), 0, resp);  // region 0 with the index in [15:0]
        check($sformatf("fb write response at %0d", idx), OKAY, resp);
        fb_model[idx] = cidx;
    endtask

    task automatic write_palette(input int idx, input logic [11:0] rgb);
        logic [1:0] resp;
        axi_write(20'h10000 | 20'(idx), 32'(rgb), 0, resp);
        check($sformatf("palette write response at %0d", idx), OKAY, resp);
        pal_model[idx] = rgb;
    endtask

    // palette records go out at once while boxes and checkpoints are kept
    task automatic read_stimulus();
        int fd, n, a, b, c, d, e;
        string line;
        byte kind;
        fd = $fopen("dv/fb_stimulus.txt", "r");
        if (fd == 0) stop_on_failure("cannot open dv/fb_stimulus.txt");
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2) continue;
            kind = line[0];
            if (kind == "P") begin
                n = $sscanf(line.substr(2, line.len() - 1), "%d %h", a, b);
                if (n != 2) stop_on_failure("bad palette record in stimulus file");
                write_palette(a, 12'(b));
            end else if (kind == "B") begin
                n = $sscanf(line.substr(2, line.len() - 1), "%d %d %d %d %d", a, b, c, d, e);
                if (n != 5 || n_box >= 16) stop_on_failure("bad box record in stimulus file");
                bx[n_box] = a;
                by[n_box] = b;
                bw[n_box] = c;
                bh[n_box] = d;
                bi[n_box] = e;
                n_box++;
            end else if (kind == "C") begin
                n = $sscanf(line.substr(2, line.len() - 1), "%d %d %h", a, b, c);
                if (n != 3 || n_chk >= 32) stop_on_failure("bad checkpoint in stimulus file");
                cx[n_chk] = a;
                cy[n_chk] = b;
                cc[n_chk] = 12'(c);
                n_chk++;
            end else if (kind != "#") begin
                stop_on_failure("unknown record type in stimulus file");
            end
        end
        $fclose(fd);
    endtask

    // returns on the first low cycle of the next vsync pulse
    task automatic wait_vsync_start();
        int t;
        t = 0;
        while (vga_vsync !== 1'b1) next_cycle(t, FRAME_MAX, "vsync high");
        while (vga_vsync !== 1'b0) next_cycle(t, FRAME_MAX, "vsync pulse");
    endtask

    // walks one frame from one vsync start to the next
    task automatic scan_frame(input bit use_points);
        int t, x, y, k, hs_len, vs_len;
        logic prev_de, prev_hs, prev_vs;
        logic [11:0] rgb;
        t = 0;
        x = 0;
        y = 0;
        hs_len = 0;
        vs_len = 0;
        prev_de = 1'b0;
        prev_hs = vga_hsync;
        prev_vs = vga_vsync;
        do begin
            rgb = {vga_r, vga_g, vga_b};
            if (vga_de) begin
                if (x < 640 && y < 480) begin
                    check($sformatf("pixel (%0d,%0d)", x, y),
                          pal_model[fb_model[(y / SCALE) * FB_W + x / SCALE]], rgb);
                    for (k = 0; k < n_chk && use_points; k++) begin
                        if (cx[k] == x && cy[k] == y)
                            check($sformatf("checkpoint (%0d,%0d)", x, y), cc[k], rgb);
                    end
                end
                x++;
            end else begin
                check("colour with de low", 0, rgb);
                if (prev_de) begin  // end of an active line
                    check("de cycles per line", 640, x);
                    x = 0;
                    y++;
                end
            end
            if (!vga_hsync) hs_len++;
            else if (!prev_hs) begin
                check("hsync width", 96, hs_len);
                hs_len = 0;
            end
            if (!vga_vsync) vs_len++;
            else if (!prev_vs) begin
                check("vsync width", 2 * LINE_LEN, vs_len);  // two lines
                vs_len = 0;
            end
            prev_de = vga_de;
            prev_hs = vga_hsync;
            prev_vs = vga_vsync;
            next_cycle(t, FRAME_MAX, "end of frame");
        end while (!(prev_vs && !vga_vsync));
        check("lines per frame", 480, y);
    endtask

    initial begin
        logic [1:0]  resp;
        logic [31:0] rdata, count_a;
        int i, b, xx, yy;
        n_box          = 0;
        n_chk          = 0;
        rng_state      = 32'd30443;
        rst            = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = 4'hf;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        repeat (2) @(negedge clk_pix);
        check("axi ready and valid in reset", 0,
              {s_axil_awready, s_axil_wready, s_axil_bvalid, s_axil_arready, s_axil_rvalid});
        check("de and colour in reset", 0, {vga_de, vga_r, vga_g, vga_b});
        rst = 1'b0;

        read_stimulus();
        for (i = 0; i < FB_W * FB_H; i++) begin  // random background
            rng_state = xorshift32(rng_state);
            write_pixel(i, rng_state[3:0]);
        end
        for (b = 0; b < n_box; b++)
            for (yy = by[b]; yy < by[b] + bh[b]; yy++)
                for (xx = bx[b]; xx < bx[b] + bw[b]; xx++)
                    write_pixel(yy * FB_W + xx, 4'(bi[b]));

        axi_write(20'(FB_W * FB_H), 32'h5, 0, resp);  // one past the last pixel
        check("write past framebuffer", SLVERR, resp);
        axi_write(20'h30000, 32'h5, 0, resp);
        check("write to region 3", SLVERR, resp);

        wait_vsync_start();
        scan_frame(1'b1);

        // one frame strobe between two vsync starts
        axi_read(20'h20000, count_a, resp);
        check("frame count response", OKAY, resp);
        wait_vsync_start();
        axi_read(20'h20000, rdata, resp);
        check("frame count response", OKAY, resp);
        check("frame count step", count_a + 32'd1, rdata);
        axi_read(20'h30000, rdata, resp);
        check("unmapped read response", SLVERR, resp);
        check("unmapped read data", 0, rdata);

        // still in vblank so the new colour shows from the next frame
        axi_write(20'h10001, 32'h5a5, 6, resp);
        check("palette rewrite response", OKAY, resp);
        pal_model[1] = 12'h5a5;
        wait_vsync_start();
        scan_frame(1'b0);  // file checkpoints assume the old palette

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/fb_display_top.sv
// ================================================
// display engine top: axi slave, timing, memories,
// scaler, sync delay and output register
// ================================================
`default_nettype none
`timescale 1ns/1ps

module fb_display_top #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120,
    parameter int FB_SCALE  = 4
) (
    input  logic                        clk_pix,
    input  logic                        rst,
    input  logic [fb_pkg::AXI_AW-1:0]   s_axil_awaddr,
    input  logic                        s_axil_awvalid,
    output logic                        s_axil_awready,
    input  logic [fb_pkg::AXI_DW-1:0]   s_axil_wdata,
    input  logic [fb_pkg::AXI_DW/8-1:0] s_axil_wstrb,
    input  logic                        s_axil_wvalid,
    output logic                        s_axil_wready,
    output logic [1:0]                  s_axil_bresp,
    output logic                        s_axil_bvalid,
    input  logic                        s_axil_bready,
    input  logic [fb_pkg::AXI_AW-1:0]   s_axil_araddr,
    input  logic                        s_axil_arvalid,
    output logic                        s_axil_arready,
    output logic [fb_pkg::AXI_DW-1:0]   s_axil_rdata,
    output logic [1:0]                  s_axil_rresp,
    output logic                        s_axil_rvalid,
    input  logic                        s_axil_rready,
    output logic                        vga_hsync,
    output logic                        vga_vsync,
    output logic                        vga_de,
    output logic [fb_pkg::CHANW-1:0]    vga_r,
    output logic [fb_pkg::CHANW-1:0]    vga_g,
    output logic [fb_pkg::CHANW-1:0]    vga_b
);

    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);

    logic                       fb_we, pal_we;
    logic [FB_ADDRW-1:0]        fb_waddr, fb_raddr;
    logic [fb_pkg::CIDXW-1:0]   fb_wdata, fb_rdata;
    logic [fb_pkg::CIDXW-1:0]   pal_waddr;
    logic [fb_pkg::COLRW-1:0]   pal_wdata, pal_colr;
    logic                       lb_we, lb_wbank, lb_ren, lb_rbank, paint;
    logic [$clog2(FB_WIDTH)-1:0] lb_wcol;
    logic [fb_pkg::CIDXW-1:0]   lb_rdata;  // palette index
    logic [1:0] hs_d, vs_d, de_d;          // first two sync stages

    disp_if disp ();

    display_timing display_timing_inst (.clk_pix, .rst, .disp(disp));

    axil_fb_slave #(.FB_PIXELS(FB_PIXELS)) axil_fb_slave_inst (
        .clk_pix, .rst,
        .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
        .s_axil_wdata, .s_axil_wstrb, .s_axil_wvalid, .s_axil_wready,
        .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
        .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
        .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
        .frame(disp.frame),
        .fb_we, .fb_addr(fb_waddr), .fb_data(fb_wdata),
        .pal_we, .pal_addr(pal_waddr), .pal_data(pal_wdata)
    );

    sdp_ram #(.WIDTH(fb_pkg::CIDXW), .DEPTH(FB_PIXELS)) fb_ram_inst (
        .clk_pix, .we(fb_we), .addr_write(fb_waddr), .data_in(fb_wdata),
        .addr_read(fb_raddr), .data_out(fb_rdata)
    );

    line_scaler_ctrl #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_SCALE(FB_SCALE)
    ) line_scaler_ctrl_inst (
        .clk_pix, .rst, .disp(disp), .fb_addr(fb_raddr),
        .lb_we, .lb_wcol, .lb_wbank, .lb_ren, .lb_rbank, .paint
    );

    line_buffer #(.FB_WIDTH(FB_WIDTH), .FB_SCALE(FB_SCALE)) line_buffer_inst (
        .clk_pix, .rst, .we(lb_we), .wcol(lb_wcol), .wbank(lb_wbank),
        .data_in(fb_rdata), .ren(lb_ren), .rbank(lb_rbank), .data_out(lb_rdata)
    );

    sdp_ram #(.WIDTH(fb_pkg::COLRW), .DEPTH(16)) pal_ram_inst (
        .clk_pix, .we(pal_we), .addr_write(pal_waddr), .data_in(pal_wdata),
        .addr_read(lb_rdata), .data_out(pal_colr)
    );

    // sync delayed 3 cycles to match the pixel path
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            hs_d      <= '1;
            vs_d      <= '1;
            de_d      <= '0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_de    <= 1'b0;
            {vga_r, vga_g, vga_b} <= '0;
        end else begin
            hs_d      <= {hs_d[0], disp.hsync};
            vs_d      <= {vs_d[0], disp.vsync};
            de_d      <= {de_d[0], disp.de};
            vga_hsync <= hs_d[1];
            vga_vsync <= vs_d[1];
            vga_de    <= de_d[1];
            {vga_r, vga_g, vga_b} <= (de_d[1] && paint) ? pal_colr : '0;  // black outside
        end
    end

endmodule

`default_nettype wire

// File: design/line_buffer.sv
// ================================================
// two-bank line store, each pixel read FB_SCALE times
// ================================================
`default_nettype none
`timescale 1ns/1ps

module line_buffer #(
    parameter int FB_WIDTH = 160,
    parameter int FB_SCALE = 4
) (
    input  logic                        clk_pix,
    input  logic                        rst,
    input  logic                        we,
    input  logic [$clog2(FB_WIDTH)-1:0] wcol,
    input  logic                        wbank,
    input  logic [fb_pkg::CIDXW-1:0]    data_in,
    input  logic                        ren,
    input  logic                        rbank,
    output logic [fb_pkg::CIDXW-1:0]    data_out
);

    localparam int COLW = $clog2(FB_WIDTH);
    localparam int REPW = $clog2(FB_SCALE+1);

    logic [fb_pkg::CIDXW-1:0] mem [2][FB_WIDTH];
    logic [COLW-1:0] rcol;
    logic [REPW-1:0] rep;  // repeats of current pixel

    always_ff @(posedge clk_pix) begin
        if (we) mem[wbank][wcol] <= data_in;
        if (ren) data_out <= mem[rbank][rcol];
    end

    // column steps every FB_SCALE enabled cycles
    always_ff @(posedge clk_pix) begin
        if (rst || !ren) begin
            rcol <= '0;
            rep  <= '0;
        end else if (rep == REPW'(FB_SCALE - 1)) begin
            rep  <= '0;
            rcol <= rcol + COLW'(1);
        end else begin
            rep <= rep + REPW'(1);
        end
    end

endmodule

`default_nettype wire

// File: design/line_scaler_ctrl.sv
// ================================================
// line buffer scheduling: row fetch fsm, bank swap,
// read enable and paint window
// ================================================
`default_nettype none
`timescale 1ns/1ps

module line_scaler_ctrl #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120,
    parameter int FB_SCALE  = 4
) (
    input  logic clk_pix,
    input  logic rst,
    disp_if.snk  disp,
    output logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] fb_addr,
    output logic                                   lb_we,
    output logic [$clog2(FB_WIDTH)-1:0]            lb_wcol,
    output logic                                   lb_wbank,
    output logic                                   lb_ren,
    output logic                                   lb_rbank,
    output logic                                   paint
);

    localparam int LAT   = 3;  // lb read, palette read, output reg
    localparam int ADDRW = $clog2(FB_WIDTH*FB_HEIGHT);
    localparam int COLW  = $clog2(FB_WIDTH);
    localparam int ROWW  = $clog2(FB_HEIGHT);
    localparam int SUBW  = $clog2(FB_SCALE+1);
    localparam int IMG_W = FB_WIDTH * FB_SCALE;
    localparam int IMG_H = FB_HEIGHT * FB_SCALE;

    fb_pkg::fill_state_t state;
    logic [SUBW-1:0] sub_cnt;   // repeat of the coming line
    logic [ROWW-1:0] row_cnt;   // fb row of the coming line
    logic [COLW-1:0] rd_col;
    logic [ROWW-1:0] fill_row;
    logic            start_fill;
    logic            swap;
    logic [LAT-2:0]  paint_pipe;

    // decided at the line strobe for line sy+1
    always_comb begin
        start_fill = 1'b0;
        fill_row   = row_cnt + ROWW'(1);
        swap       = 1'b0;
        if (disp.line) begin
            if (disp.sy == -1) begin  // first image line next
                start_fill = 1'b1;
                fill_row   = '0;
            end else if (disp.sy >= 0 && disp.sy < IMG_H - 1) begin
                start_fill = (sub_cnt == SUBW'(FB_SCALE - 1));
            end
            swap = (disp.sy >= 0 && disp.sy < IMG_H && sub_cnt == '0);
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sub_cnt  <= '0;
            row_cnt  <= '0;
            lb_rbank <= 1'b0;
        end else if (disp.line) begin
            lb_rbank <= lb_rbank ^ swap;
            if (disp.sy == -1) begin
                sub_cnt <= '0;
                row_cnt <= '0;
            end else if (disp.sy >= 0 && disp.sy < IMG_H - 1) begin
                if (start_fill) begin
                    sub_cnt <= '0;
                    row_cnt <= fill_row;
                end else begin
                    sub_cnt <= sub_cnt + SUBW'(1);
                end
            end
        end
    end

    // row fetch, one read per cycle
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state    <= fb_pkg::FILL_IDLE;
            lb_wbank <= 1'b1;
        end else begin
            case (state)
                fb_pkg::FILL_IDLE: begin
                    if (start_fill) begin
                        fb_addr  <= ADDRW'(fill_row * FB_WIDTH);
                        rd_col   <= '0;
                        lb_wbank <= ~(lb_rbank ^ swap);  // bank not on screen
                        state    <= fb_pkg::FILL_RUN;
                    end
                end
                fb_pkg::FILL_RUN: begin
                    fb_addr <= fb_addr + ADDRW'(1);
                    rd_col  <= rd_col + COLW'(1);
                    if (rd_col == COLW'(FB_WIDTH - 1)) state <= fb_pkg::FILL_DONE;
                end
                default: state <= fb_pkg::FILL_IDLE;  // last write lands
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        lb_wcol <= rd_col;  // ram data arrives a cycle after the read
        if (rst) lb_we <= 1'b0;
        else lb_we <= (state == fb_pkg::FILL_RUN);
    end

    // enable one cycle before the window so lb reads at sx
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            lb_ren     <= 1'b0;
            paint_pipe <= '0;
        end else begin
            lb_ren <= (disp.sy >= 0 && disp.sy < IMG_H && disp.sx >= -1 && disp.sx < IMG_W - 1);
            paint_pipe <= {paint_pipe[LAT-3:0], lb_ren};
        end
    end

    assign paint = paint_pipe[LAT-2];  // lines up with palette out

endmodule

`default_nettype wire

// File: design/axil_fb_slave.sv
// ================================================
// axi4-lite slave: framebuffer and palette writes,
// frame counter read
// ================================================
`default_nettype none
`timescale 1ns/1ps

module axil_fb_slave #(
    parameter int FB_PIXELS = 19200
) (
    input  logic                       clk_pix,
    input  logic                       rst,
    input  logic [fb_pkg::AXI_AW-1:0]  s_axil_awaddr,
    input  logic                       s_axil_awvalid,
    output logic                       s_axil_awready,
    input  logic [fb_pkg::AXI_DW-1:0]  s_axil_wdata,
    input  logic [fb_pkg::AXI_DW/8-1:0] s_axil_wstrb,
    input  logic                       s_axil_wvalid,
    output logic                       s_axil_wready,
    output logic [1:0]                 s_axil_bresp,
    output logic                       s_axil_bvalid,
    input  logic                       s_axil_bready,
    input  logic [fb_pkg::AXI_AW-1:0]  s_axil_araddr,
    input  logic                       s_axil_arvalid,
    output logic                       s_axil_arready,
    output logic [fb_pkg::AXI_DW-1:0]  s_axil_rdata,
    output logic [1:0]                 s_axil_rresp,
    output logic                       s_axil_rvalid,
    input  logic                       s_axil_rready,
    input  logic                       frame,
    output logic                       fb_we,
    output logic [$clog2(FB_PIXELS)-1:0] fb_addr,
    output logic [fb_pkg::CIDXW-1:0]   fb_data,
    output logic                       pal_we,
    output logic [fb_pkg::CIDXW-1:0]   pal_addr,
    output logic [fb_pkg::COLRW-1:0]   pal_data
);

    localparam int FB_ADDRW = $clog2(FB_PIXELS);
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    fb_pkg::axil_state_t state;
    logic [31:0] frame_cnt;

    // bits 17:16 pick the target, anything above must be zero
    function automatic fb_pkg::region_t decode(input logic [fb_pkg::AXI_AW-1:0] addr);
        if (addr[fb_pkg::AXI_AW-1:18] != '0) return fb_pkg::REGION_NONE;
        case (addr[17:16])
            2'd0:    return fb_pkg::REGION_FB;
            2'd1:    return fb_pkg::REGION_PAL;
            2'd2:    return fb_pkg::REGION_STATUS;
            default: return fb_pkg::REGION_NONE;
        endcase
    endfunction

    always_ff @(posedge clk_pix) begin
        if (rst) frame_cnt <= '0;
        else if (frame) frame_cnt <= frame_cnt + 32'd1;
    end

    always_ff @(posedge clk_pix) begin
        fb_we  <= 1'b0;  // strobes last one cycle
        pal_we <= 1'b0;
        if (rst) begin
            state          <= fb_pkg::AXS_IDLE;
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_bvalid  <= 1'b0;
            s_axil_arready <= 1'b0;
            s_axil_rvalid  <= 1'b0;
        end else begin
            case (state)
                fb_pkg::AXS_IDLE: begin
                    if (s_axil_arready) begin  // read handshake this cycle
                        s_axil_arready <= 1'b0;
                        s_axil_rvalid  <= 1'b1;
                        if (s_axil_araddr == fb_pkg::REG_FRAME_COUNT) begin
                            s_axil_rdata <= frame_cnt;
                            s_axil_rresp <= RESP_OKAY;
                        end else begin
                            s_axil_rdata <= '0;
                            s_axil_rresp <= RESP_SLVERR;
                        end
                        state <= fb_pkg::AXS_RDATA;
                    end else if (s_axil_awvalid && s_axil_wvalid) begin  // write wins
                        s_axil_awready <= 1'b1;
                        s_axil_wready  <= 1'b1;
                        state          <= fb_pkg::AXS_WRITE;
                    end else if (s_axil_arvalid) begin
                        s_axil_arready <= 1'b1;
                    end
                end
                fb_pkg::AXS_WRITE: begin  // aw and w complete here
                    s_axil_awready <= 1'b0;
                    s_axil_wready  <= 1'b0;
                    s_axil_bvalid  <= 1'b1;
                    s_axil_bresp   <= RESP_SLVERR;
                    fb_addr        <= s_axil_awaddr[FB_ADDRW-1:0];
                    fb_data        <= s_axil_wdata[fb_pkg::CIDXW-1:0];
                    pal_addr       <= s_axil_awaddr[fb_pkg::CIDXW-1:0];
                    pal_data       <= s_axil_wdata[fb_pkg::COLRW-1:0];
                    case (decode(s_axil_awaddr))
                        fb_pkg::REGION_FB: begin
                            if (s_axil_awaddr[15:0] < FB_PIXELS) begin
                                fb_we        <= 1'b1;
                                s_axil_bresp <= RESP_OKAY;
                            end
                        end
                        fb_pkg::REGION_PAL: begin
                            pal_we       <= 1'b1;
                            s_axil_bresp <= RESP_OKAY;
                        end
                        default: ;  // status is read only
                    endcase
                    state <= fb_pkg::AXS_WRESP;
                end
                fb_pkg::AXS_WRESP: begin
                    if (s_axil_bready) begin
                        s_axil_bvalid <= 1'b0;
                        state         <= fb_pkg::AXS_IDLE;
                    end
                end
                default: begin  // AXS_RDATA
                    if (s_axil_rready) begin
                        s_axil_rvalid <= 1'b0;
                        state         <= fb_pkg::AXS_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/sdp_ram.sv
// ================================================
// simple dual-port ram, sync write, registered read
// ================================================
`default_nettype none
`timescale 1ns/1ps

module sdp_ram #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 256
) (
    input  logic                     clk_pix,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr_write,
    input  logic [WIDTH-1:0]         data_in,
    input  logic [$clog2(DEPTH)-1:0] addr_read,
    output logic [WIDTH-1:0]         data_out
);

    logic [WIDTH-1:0] mem [DEPTH];  // contents undefined until written

    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
        data_out <= mem[addr_read];  // one cycle latency
    end

endmodule

`default_nettype wire

// File: design/display_timing.sv
// ================================================
// 640x480 counters with signed coordinates,
// registered sync, de and line/frame strobes
// ================================================
`default_nettype none
`timescale 1ns/1ps

module display_timing (
    input  logic clk_pix,
    input  logic rst,
    disp_if.src  disp
);

    localparam int CORDW = fb_pkg::CORDW;
    localparam logic signed [CORDW-1:0] H_STA  = CORDW'(-fb_pkg::H_BLANK);
    localparam logic signed [CORDW-1:0] V_STA  = CORDW'(-fb_pkg::V_BLANK);
    localparam logic signed [CORDW-1:0] H_END  = CORDW'(fb_pkg::H_RES - 1);
    localparam logic signed [CORDW-1:0] V_END  = CORDW'(fb_pkg::V_RES - 1);
    localparam logic signed [CORDW-1:0] HS_STA = H_STA + CORDW'(fb_pkg::H_FP);
    localparam logic signed [CORDW-1:0] HS_END = HS_STA + CORDW'(fb_pkg::H_SYNC - 1);
    localparam logic signed [CORDW-1:0] VS_STA = V_STA + CORDW'(fb_pkg::V_FP);
    localparam logic signed [CORDW-1:0] VS_END = VS_STA + CORDW'(fb_pkg::V_SYNC - 1);

    logic signed [CORDW-1:0] sx_next;
    logic signed [CORDW-1:0] sy_next;

    // flags come from the next count so they line up with sx/sy
    always_comb begin
        if (disp.sx == H_END) begin
            sx_next = H_STA;
            sy_next = (disp.sy == V_END) ? V_STA : disp.sy + CORDW'(1);
        end else begin
            sx_next = disp.sx + CORDW'(1);
            sy_next = disp.sy;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            disp.sx    <= H_STA;  // back to frame start
            disp.sy    <= V_STA;
            disp.hsync <= 1'b1;
            disp.vsync <= 1'b1;
            disp.de    <= 1'b0;
            disp.line  <= 1'b0;
            disp.frame <= 1'b0;
        end else begin
            disp.sx    <= sx_next;
            disp.sy    <= sy_next;
            disp.hsync <= ~(sx_next >= HS_STA && sx_next <= HS_END);
            disp.vsync <= ~(sy_next >= VS_STA && sy_next <= VS_END);
            disp.de    <= (sx_next >= 0 && sy_next >= 0);
            disp.line  <= (sx_next == H_STA);
            disp.frame <= (sx_next == H_STA && sy_next == V_STA);
        end
    end

endmodule

`default_nettype wire

// File: design/disp_if.sv
// ================================================
// display timing bundle: coords, sync, de, strobes
// ================================================
`default_nettype none
`timescale 1ns/1ps

interface disp_if;
    logic signed [fb_pkg::CORDW-1:0] sx;  // negative in blanking
    logic signed [fb_pkg::CORDW-1:0] sy;
    logic hsync;  // active low
    logic vsync;  // active low
    logic de;
    logic line;   // first cycle of each line
    logic frame;  // first cycle of each frame

    modport src (output sx, sy, hsync, vsync, de, line, frame);
    modport snk (input sx, sy, hsync, vsync, de, line, frame);
endinterface

`default_nettype wire

// File: design/fb_pkg.sv
// ================================================
// shared package: 480p timing, colour widths,
// axi address map and state enums
// ================================================
`default_nettype none

package fb_pkg;

    // 640x480 active area and blanking
    localparam int H_RES   = 640;
    localparam int V_RES   = 480;
    localparam int H_FP    = 16;
    localparam int H_SYNC  = 96;
    localparam int H_BP    = 48;
    localparam int V_FP    = 10;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 33;
    localparam int H_BLANK = H_FP + H_SYNC + H_BP;  // 160
    localparam int V_BLANK = V_FP + V_SYNC + V_BP;  // 45

    localparam int CORDW = 16;         // signed screen coords
    localparam int CHANW = 4;          // bits per channel
    localparam int COLRW = 3 * CHANW;  // rgb
    localparam int CIDXW = 4;          // palette index

    localparam int AXI_AW = 20;
    localparam int AXI_DW = 32;
    localparam logic [AXI_AW-1:0] REG_FRAME_COUNT = AXI_AW'('h20000);

    typedef enum logic [1:0] {AXS_IDLE, AXS_WRITE, AXS_WRESP, AXS_RDATA} axil_state_t;
    typedef enum logic [1:0] {REGION_FB, REGION_PAL, REGION_STATUS, REGION_NONE} region_t;
    typedef enum logic [1:0] {FILL_IDLE, FILL_RUN, FILL_DONE} fill_state_t;

endpackage

`default_nettype wire
